/* vlog.f */
rtl/board_pkg.sv
rtl/board_reset.sv
rtl/board_dip.sv
rtl/board_inputs.sv
rtl/board_led.sv
rtl/board_color.sv
rtl/board_top.sv
test/board_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module board_tb -f vlog.f -o board_sim
out=$(./obj_dir/board_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All tests passed!"; then
    exit 0
fi
exit 1

/* test/board_tb.sv */
// Directed testbench for the arcade board wrapper
`timescale 1ns/1ps
`default_nettype none

module board_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int COLORW      = 4;
    // About five times the length of the directed sequence
    localparam int WATCHDOG_NS = 2000 * CLK_PERIOD;
    localparam board_pkg::joy_t JOY_IDLE = 10'h3ff;

    logic                clk_sys;
    logic                arst_n;
    logic                pll_locked;
    logic                rst_req;
    logic                downloading;
    logic                osd_shown;
    logic [63:0]         status;
    logic [1:0]          game_led;
    logic                vs;
    logic                lhbl;
    logic                lvbl;
    logic                pxl_cen;
    logic [15:0]         board_joystick1;
    logic [15:0]         board_joystick2;
    logic [3:0]          board_coin;
    logic [3:0]          board_start;
    logic [COLORW-1:0]   game_r;
    logic [COLORW-1:0]   game_g;
    logic [COLORW-1:0]   game_b;
    logic                rst;
    logic                game_rst;
    logic                led;
    board_pkg::dip_cfg_t cfg;
    board_pkg::joy_t     game_joystick1;
    board_pkg::joy_t     game_joystick2;
    logic [3:0]          game_coin;
    logic [3:0]          game_start;
    board_pkg::rgb8_t    video;
    logic                video_de;

    integer seed = 32'he058_8f5e;
    int     errors = 0;
    int     checks = 0;
    // Number of vs rises since reset
    int     vs_count = 0;

    board_top #(
        .COLORW                 ( COLORW ),
        .GAME_INPUTS_ACTIVE_LOW ( 1'b1   )
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    task automatic check_cfg(input board_pkg::dip_cfg_t got, input board_pkg::dip_cfg_t want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_joy(input board_pkg::joy_t got, input board_pkg::joy_t want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_nibble(input logic [3:0] got, input logic [3:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_rgb(input board_pkg::rgb8_t got, input board_pkg::rgb8_t want,
                             input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_cycles(input int got, input int want, input string what);
        checks++;
        if (got != want) begin
            errors++;
            $display("Error at %0t ns: %s took %0d cycles, expected %0d", $time, what, got, want);
        end
    endtask

    function automatic board_pkg::dip_cfg_t decode_status(input logic [63:0] st, input logic osd);
        board_pkg::dip_cfg_t c;
        c.rotate      = st[board_pkg::ST_ROTATE_LSB +: 2];
        c.scanlines   = st[board_pkg::ST_SCAN_LSB +: 3];
        c.enable_fm   = !st[board_pkg::ST_NO_FM];
        c.enable_psg  = !st[board_pkg::ST_NO_PSG];
        c.dip_pause   = !(osd && st[board_pkg::ST_OSD_PAUSE]);
        c.dip_flip    = st[board_pkg::ST_FLIP];
        c.dip_fxlevel = st[board_pkg::ST_FX_LSB +: 2];
        c.dip_test    = !st[board_pkg::ST_TEST];
        return c;
    endfunction

    // Channel bits repeated from the top, first 8 kept
    function automatic logic [7:0] stretch_channel(input logic [COLORW-1:0] c);
        logic [8*COLORW-1:0] rep;
        rep = {8{c}};
        return rep[8*COLORW-1 -: 8];
    endfunction

    task automatic count_release(input bit game, output int cycles);
        cycles = 0;
        while ((game ? game_rst : rst) === 1'b1 && cycles < 4 * board_pkg::RST_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
            @(negedge clk_sys);
        end
        if (cycles >= 4 * board_pkg::RST_CYCLES) begin
            errors++;
            $display("The %s reset never released", game ? "game" : "system");
        end
    endtask

    task automatic pulse_vs();
        @(posedge clk_sys);
        vs <= 1'b1;
        repeat (3) @(posedge clk_sys);
        vs <= 1'b0;
        repeat (3) @(posedge clk_sys);
        vs_count++;
        @(negedge clk_sys);
    endtask

    task automatic pulse_lvbl();
        @(posedge clk_sys);
        lvbl <= 1'b0;
        @(posedge clk_sys);
        lvbl <= 1'b1;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic reset_sequence();
        int cycles;
        repeat (7) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(rst, 1'b1, "rst in reset");
        check_bit(game_rst, 1'b1, "game_rst in reset");
        check_bit(led, 1'b0, "led in reset");
        check_bit(video_de, 1'b0, "video_de in reset");
        check_cfg(cfg, '0, "cfg in reset");
        check_joy(game_joystick1, JOY_IDLE, "joystick 1 in reset");
        check_joy(game_joystick2, JOY_IDLE, "joystick 2 in reset");
        check_nibble(game_coin, 4'hf, "coin in reset");
        check_nibble(game_start, 4'hf, "start in reset");
        @(posedge clk_sys);
        arst_n <= 1'b1;
        count_release(1'b0, cycles);
        check_cycles(cycles, board_pkg::RST_CYCLES, "rst release");
        // Download still held, so the game stays in reset
        repeat (board_pkg::RST_CYCLES + 4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(game_rst, 1'b1, "game_rst while downloading");
        @(posedge clk_sys);
        downloading <= 1'b0;
        count_release(1'b1, cycles);
        check_cycles(cycles, board_pkg::RST_CYCLES, "game_rst release");
        @(posedge clk_sys);
        status <= 64'h1 << board_pkg::ST_SOFT_RST;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(game_rst, 1'b1, "game_rst on soft reset");
        check_bit(rst, 1'b0, "rst on soft reset");
        @(posedge clk_sys);
        status <= '0;
        // One extra cycle for the registered soft reset bit
        count_release(1'b1, cycles);
        check_cycles(cycles, board_pkg::RST_CYCLES + 1, "soft reset release");
    endtask

    task automatic status_decode();
        logic [63:0] w;
        for (int n = 0; n < 8; n++) begin
            for (int osd = 0; osd < 2; osd++) begin
                w = {$random(seed), $random(seed)};
                w[board_pkg::ST_SOFT_RST] = 1'b0;
                w[board_pkg::ST_AUTOFIRE] = 1'b0;
                @(posedge clk_sys);
                status    <= w;
                osd_shown <= osd[0];
                repeat (2) @(posedge clk_sys);
                @(negedge clk_sys);
                check_cfg(cfg, decode_status(w, osd[0]), "cfg");
            end
        end
        @(posedge clk_sys);
        status    <= '0;
        osd_shown <= 1'b0;
    endtask

    task automatic frame_sampling();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        rnd = $random(seed);
        rnd2 = $random(seed);
        @(posedge clk_sys);
        board_joystick1 <= rnd[15:0];
        board_joystick2 <= rnd[31:16];
        board_coin      <= rnd2[3:0];
        board_start     <= rnd2[7:4];
        pulse_vs();
        check_joy(game_joystick1, board_pkg::joy_t'(~rnd[9:0]), "joystick 1");
        check_joy(game_joystick2, board_pkg::joy_t'(~rnd[25:16]), "joystick 2");
        check_nibble(game_coin, ~rnd2[3:0], "coin");
        check_nibble(game_start, ~rnd2[7:4], "start");
        // Mid-frame changes must wait for the next vs
        @(posedge clk_sys);
        board_joystick1 <= ~rnd[15:0];
        board_joystick2 <= ~rnd[31:16];
        board_coin      <= ~rnd2[3:0];
        board_start     <= ~rnd2[7:4];
        repeat (5) @(posedge clk_sys);
        @(negedge clk_sys);
        check_joy(game_joystick1, board_pkg::joy_t'(~rnd[9:0]), "joystick 1 mid-frame");
        check_joy(game_joystick2, board_pkg::joy_t'(~rnd[25:16]), "joystick 2 mid-frame");
        check_nibble(game_coin, ~rnd2[3:0], "coin mid-frame");
        check_nibble(game_start, ~rnd2[7:4], "start mid-frame");
        @(posedge clk_sys);
        downloading <= 1'b1;
        pulse_vs();
        check_joy(game_joystick1, JOY_IDLE, "joystick 1 while downloading");
        check_joy(game_joystick2, JOY_IDLE, "joystick 2 while downloading");
        check_nibble(game_coin, 4'hf, "coin while downloading");
        check_nibble(game_start, 4'hf, "start while downloading");
        @(posedge clk_sys);
        downloading <= 1'b0;
        pulse_vs();
        check_joy(game_joystick1, board_pkg::joy_t'(rnd[9:0]), "joystick 1 next frame");
        check_joy(game_joystick2, board_pkg::joy_t'(rnd[25:16]), "joystick 2 next frame");
        check_nibble(game_coin, rnd2[3:0], "coin next frame");
        check_nibble(game_start, rnd2[7:4], "start next frame");
    endtask

    task automatic autofire_alternation();
        board_pkg::joy_t held;
        board_pkg::joy_t want1;
        held = '0;
        held.buttons[0] = 1'b1;
        held.left = 1'b1;
        @(posedge clk_sys);
        status          <= 64'h1 << board_pkg::ST_AUTOFIRE;
        board_joystick1 <= {6'h0, held};
        board_joystick2 <= {6'h0, held};
        repeat (2) @(posedge clk_sys);
        for (int n = 0; n < 6; n++) begin
            pulse_vs();
            // Button 0 reads pressed in odd frames
            want1 = ~held;
            want1.buttons[0] = (vs_count % 2 == 1) ? 1'b0 : 1'b1;
            check_joy(game_joystick1, want1, "joystick 1 autofire");
            check_joy(game_joystick2, ~held, "joystick 2 with autofire");
        end
        @(posedge clk_sys);
        status <= '0;
    endtask

    task automatic led_blink_and_level();
        logic [2:0] combo;
        @(posedge clk_sys);
        downloading <= 1'b1;
        // Game LED lit, so the blink has to override it
        game_led    <= 2'b01;
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(led, 1'b0, "led at download start");
        for (int f = 1; f <= 3 * board_pkg::BLINK_FRAMES; f++) begin
            pulse_lvbl();
            check_bit(led, ((f / board_pkg::BLINK_FRAMES) % 2) == 1, "led while downloading");
        end
        @(posedge clk_sys);
        downloading <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            combo = 3'(i);
            @(posedge clk_sys);
            osd_shown <= combo[2];
            game_led  <= combo[1:0];
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            check_bit(led, combo[2] | combo[0], "led level");
        end
        @(posedge clk_sys);
        osd_shown <= 1'b0;
        game_led  <= 2'b00;
    endtask

    task automatic color_widening();
        logic [31:0]       rnd;
        logic [COLORW-1:0] r;
        logic [COLORW-1:0] g;
        logic [COLORW-1:0] b;
        board_pkg::rgb8_t  want;
        for (int n = 0; n < 8; n++) begin
            rnd = $random(seed);
            r = rnd[0 +: COLORW];
            g = rnd[8 +: COLORW];
            b = rnd[16 +: COLORW];
            want.r = stretch_channel(r);
            want.g = stretch_channel(g);
            want.b = stretch_channel(b);
            @(posedge clk_sys);
            game_r  <= r;
            game_g  <= g;
            game_b  <= b;
            lhbl    <= rnd[24];
            lvbl    <= rnd[25];
            pxl_cen <= 1'b1;
            @(posedge clk_sys);
            pxl_cen <= 1'b0;
            @(negedge clk_sys);
            check_rgb(video, want, "video");
            check_bit(video_de, rnd[24] & rnd[25], "video_de");
            // Outputs hold without a pixel strobe
            @(posedge clk_sys);
            game_r <= ~r;
            game_g <= ~g;
            game_b <= ~b;
            lhbl   <= ~(rnd[24] & rnd[25]);
            lvbl   <= 1'b1;
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            check_rgb(video, want, "video between strobes");
            check_bit(video_de, rnd[24] & rnd[25], "video_de between strobes");
        end
        @(posedge clk_sys);
        lhbl <= 1'b1;
        lvbl <= 1'b1;
    endtask

    initial begin
        clk_sys         = 1'b0;
        arst_n          = 1'b0;
        pll_locked      = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b1;
        osd_shown       = 1'b0;
        status          = '0;
        game_led        = 2'b00;
        vs              = 1'b0;
        lhbl            = 1'b1;
        lvbl            = 1'b1;
        pxl_cen         = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_coin      = '0;
        board_start     = '0;
        game_r          = '0;
        game_g          = '0;
        game_b          = '0;
        reset_sequence();
        status_decode();
        frame_sampling();
        autofire_alternation();
        led_blink_and_level();
        color_widening();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/board_top.sv */
// Arcade board wrapper top level
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int COLORW                 = 4,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                clk_sys,
    input  logic                arst_n,
    input  logic                pll_locked,
    input  logic                rst_req,
    input  logic                downloading,
    input  logic                osd_shown,
    input  logic [63:0]         status,
    input  logic [1:0]          game_led,
    input  logic                vs,
    input  logic                lhbl,
    input  logic                lvbl,
    input  logic                pxl_cen,
    input  logic [15:0]         board_joystick1,
    input  logic [15:0]         board_joystick2,
    input  logic [3:0]          board_coin,
    input  logic [3:0]          board_start,
    input  logic [COLORW-1:0]   game_r,
    input  logic [COLORW-1:0]   game_g,
    input  logic [COLORW-1:0]   game_b,
    output logic                rst,
    output logic                game_rst,
    output logic                led,
    output board_pkg::dip_cfg_t cfg,
    output board_pkg::joy_t     game_joystick1,
    output board_pkg::joy_t     game_joystick2,
    output logic [3:0]          game_coin,
    output logic [3:0]          game_start,
    output board_pkg::rgb8_t    video,
    output logic                video_de
);

    logic soft_rst;
    logic autofire_en;

    board_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    board_dip u_dip (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .status      ( status      ),
        .osd_shown   ( osd_shown   ),
        .cfg         ( cfg         ),
        .soft_rst    ( soft_rst    ),
        .autofire_en ( autofire_en )
    );

    board_inputs #(
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW )
    ) u_inputs (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .vs              ( vs              ),
        .downloading     ( downloading     ),
        .autofire_en     ( autofire_en     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_coin      ( board_coin      ),
        .board_start     ( board_start     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      )
    );

    board_led u_led (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .lvbl        ( lvbl        ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

    board_color #(
        .COLORW ( COLORW )
    ) u_color (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .video    ( video    ),
        .video_de ( video_de )
    );

endmodule

`default_nettype wire

/* rtl/board_color.sv */
// Game colour widening to 8-bit channels
`timescale 1ns/1ps
`default_nettype none

module board_color #(
    parameter int COLORW = 4
) (
    input  logic              clk_sys,
    input  logic              rst,
    input  logic              pxl_cen,
    input  logic              lhbl,
    input  logic              lvbl,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    output board_pkg::rgb8_t  video,
    output logic              video_de
);

    if (COLORW < 3 || COLORW > 8) begin : g_bad_colorw
        $error("COLORW must be between 3 and 8");
    end

    // Repeat the channel bits from the MSB down until 8 bits are filled
    function automatic logic [7:0] widen(input logic [COLORW-1:0] c);
        logic [7:0] w;
        for (int i = 0; i < 8; i++) begin
            w[7-i] = c[COLORW-1-(i % COLORW)];
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            video.r <= widen(game_r);
            video.g <= widen(game_g);
            video.b <= widen(game_b);
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            video_de <= 1'b0;
        end else if (pxl_cen) begin
            video_de <= lhbl & lvbl;
        end
    end

    a_pixel_rate : assert property (@(posedge clk_sys) disable iff (rst)
        $changed(video) |-> $past(pxl_cen));

endmodule

`default_nettype wire

/* rtl/board_led.sv */
// Status LED with download blinking
`timescale 1ns/1ps
`default_nettype none

module board_led (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int CNTW = $clog2(board_pkg::BLINK_FRAMES);

    logic            lvbl_l;
    logic            blink;
    logic [CNTW-1:0] frame_cnt;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            blink     <= 1'b0;
            frame_cnt <= '0;
            led       <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (!downloading) begin
                blink     <= 1'b0;
                frame_cnt <= '0;
            end else if (lvbl_l && !lvbl) begin
                // One count per start of vertical blank
                if (frame_cnt == CNTW'(board_pkg::BLINK_FRAMES - 1)) begin
                    frame_cnt <= '0;
                    blink     <= ~blink;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
            led <= downloading ? blink : (osd_shown | game_led[0]);
        end
    end

endmodule

`default_nettype wire

/* rtl/board_inputs.sv */
// Frame-sampled game input conditioning
`timescale 1ns/1ps
`default_nettype none

module board_inputs #(
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic            clk_sys,
    input  logic            rst,
    input  logic            vs,
    input  logic            downloading,
    input  logic            autofire_en,
    input  logic [15:0]     board_joystick1,
    input  logic [15:0]     board_joystick2,
    input  logic [3:0]      board_coin,
    input  logic [3:0]      board_start,
    output board_pkg::joy_t game_joystick1,
    output board_pkg::joy_t game_joystick2,
    output logic [3:0]      game_coin,
    output logic [3:0]      game_start
);

    // Idle level of every game input
    localparam logic [9:0] JOY_REL = {10{GAME_INPUTS_ACTIVE_LOW}};
    localparam logic [3:0] BTN_REL = {4{GAME_INPUTS_ACTIVE_LOW}};

    logic            vs_s;
    logic            vs_d;
    logic            vs_rise;
    logic            frame_tgl;
    board_pkg::joy_t p1_raw;

    assign vs_rise = vs_s & ~vs_d;

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            vs_s      <= 1'b0;
            vs_d      <= 1'b0;
            frame_tgl <= 1'b0;
        end else begin
            vs_s <= vs;
            vs_d <= vs_s;
            if (vs_rise) begin
                frame_tgl <= ~frame_tgl;
            end
        end
    end

    // Autofire masks button 0 in frames that start with the toggle low
    always_comb begin
        p1_raw = board_pkg::joy_t'(board_joystick1[9:0]);
        if (autofire_en && frame_tgl) begin
            p1_raw.buttons[0] = 1'b0;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            game_joystick1 <= board_pkg::joy_t'(JOY_REL);
            game_joystick2 <= board_pkg::joy_t'(JOY_REL);
            game_coin      <= BTN_REL;
            game_start     <= BTN_REL;
        end else if (downloading) begin
            game_joystick1 <= board_pkg::joy_t'(JOY_REL);
            game_joystick2 <= board_pkg::joy_t'(JOY_REL);
            game_coin      <= BTN_REL;
            game_start     <= BTN_REL;
        end else if (vs_rise) begin
            game_joystick1 <= board_pkg::joy_t'(p1_raw ^ JOY_REL);
            game_joystick2 <= board_pkg::joy_t'(board_joystick2[9:0] ^ JOY_REL);
            game_coin      <= board_coin ^ BTN_REL;
            game_start     <= board_start ^ BTN_REL;
        end
    end

    a_hold_in_frame : assert property (@(posedge clk_sys) disable iff (rst)
        !$past(vs_rise) && !$past(downloading) |->
        $stable({game_joystick1, game_joystick2, game_coin, game_start}));

endmodule

`default_nettype wire

/* rtl/board_dip.sv */
// Status word decoding into DIP settings
`timescale 1ns/1ps
`default_nettype none

module board_dip (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic [63:0]         status,
    input  logic                osd_shown,
    output board_pkg::dip_cfg_t cfg,
    output logic                soft_rst,
    output logic                autofire_en
);

    board_pkg::dip_cfg_t cfg_next;

    always_comb begin
        cfg_next.rotate      = status[board_pkg::ST_ROTATE_LSB +: 2];
        cfg_next.scanlines   = status[board_pkg::ST_SCAN_LSB +: 3];
        cfg_next.enable_fm   = ~status[board_pkg::ST_NO_FM];
        cfg_next.enable_psg  = ~status[board_pkg::ST_NO_PSG];
        // Pause only takes effect with the OSD open
        cfg_next.dip_pause   = ~(osd_shown & status[board_pkg::ST_OSD_PAUSE]);
        cfg_next.dip_flip    = status[board_pkg::ST_FLIP];
        cfg_next.dip_fxlevel = status[board_pkg::ST_FX_LSB +: 2];
        cfg_next.dip_test    = ~status[board_pkg::ST_TEST];
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            cfg         <= '0;
            soft_rst    <= 1'b0;
            autofire_en <= 1'b0;
        end else begin
            cfg         <= cfg_next;
            soft_rst    <= status[board_pkg::ST_SOFT_RST];
            autofire_en <= status[board_pkg::ST_AUTOFIRE];
        end
    end

endmodule

`default_nettype wire

/* rtl/board_reset.sv */
// System and game reset sequencer
`timescale 1ns/1ps
`default_nettype none

module board_reset (
    input  logic clk_sys,
    input  logic arst_n,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic rst,
    output logic game_rst
);

    localparam int CNTW = $clog2(board_pkg::RST_CYCLES);
    // The two sync flops and the first count edge take part of the budget
    localparam logic [CNTW-1:0] SYS_LOAD  = CNTW'(board_pkg::RST_CYCLES - 3);
    localparam logic [CNTW-1:0] GAME_LOAD = CNTW'(board_pkg::RST_CYCLES - 1);

    logic [1:0]      sync;
    logic [CNTW-1:0] sys_cnt;
    logic [CNTW-1:0] game_cnt;
    logic            game_hold;

    // Game reset rises in the same cycle as the system reset
    assign game_hold = rst | ~sync[1] | downloading | soft_rst;

    // PLL lock and reset request go through the same release chain
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sync <= '0;
        end else begin
            sync <= {sync[0], pll_locked & ~rst_req};
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sys_cnt <= SYS_LOAD;
            rst     <= 1'b1;
        end else if (!sync[1]) begin
            sys_cnt <= SYS_LOAD;
            rst     <= 1'b1;
        end else if (sys_cnt != '0) begin
            sys_cnt <= sys_cnt - 1'b1;
        end else begin
            rst <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            game_cnt <= GAME_LOAD;
            game_rst <= 1'b1;
        end else if (game_hold) begin
            game_cnt <= GAME_LOAD;
            game_rst <= 1'b1;
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Game logic never runs while the system is held
    a_game_covers_sys : assert property (@(posedge clk_sys) rst |-> game_rst);

endmodule

`default_nettype wire

/* rtl/board_pkg.sv */
// Arcade board shared types and constants
`default_nettype none

package board_pkg;

    // One player's controls, directions in the low nibble
    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } joy_t;

    // Decoded DIP and OSD settings
    typedef struct packed {
        logic [1:0] rotate;
        logic [2:0] scanlines;
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_pause;      // active low
        logic       dip_flip;
        logic [1:0] dip_fxlevel;
        logic       dip_test;       // active low
    } dip_cfg_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb8_t;

    // Status word bit positions
    localparam int ST_SOFT_RST   = 0;
    localparam int ST_ROTATE_LSB = 1;
    localparam int ST_SCAN_LSB   = 3;
    localparam int ST_NO_FM      = 6;
    localparam int ST_NO_PSG     = 7;
    localparam int ST_OSD_PAUSE  = 8;
    localparam int ST_FLIP       = 9;
    localparam int ST_FX_LSB     = 10;
    localparam int ST_TEST       = 12;
    localparam int ST_AUTOFIRE   = 18;

    localparam int RST_CYCLES    = 16;
    localparam int BLINK_FRAMES  = 8;

endpackage

`default_nettype wire
